/* src.f */
+incdir+verilog
verilog/pbus_pkg.sv
verilog/gpio_pkg.sv
verilog/pbus_arbiter.sv
verilog/pbus_router.sv
verilog/gpio_port.sv
verilog/scratch_ram.sv
verilog/periph_top.sv
tests/tb_clkgen.sv
tests/tb_periph_top.sv

/* tests/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk_o,     // 20 ns period
    output logic resetn_o   // low for the first 3 cycles
);
    initial
    begin
        clk_o = 1'b0;
        forever
            #10 clk_o = ~clk_o;
    end

    initial
    begin
        resetn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        resetn_o <= 1'b1;   // release on the third edge
    end

endmodule : tb_clkgen

/* tests/tb_periph_top.sv */
// peripheral subsystem testbench
`timescale 1ns/1ps

`include "periph_consts.svh"

module tb_periph_top;
    import pbus_pkg::*;
    import gpio_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;   // about 4x the ~450 bus cycles used
    localparam int STREAM_LEN     = 50;     // accesses per master in the contention run

    logic    clk;
    logic    resetn;
    logic    a_req_i, a_we_i, a_gnt_o;      // master a
    addr_t   a_addr_i;
    data_t   a_wd_i, a_rd_o;
    logic    b_req_i, b_we_i, b_gnt_o;      // master b
    addr_t   b_addr_i;
    data_t   b_wd_i, b_rd_o;
    gpio8_t  gpio_a_gpi_i, gpio_a_gpo_o, gpio_a_gpd_o;
    gpio16_t gpio_b_gpi_i, gpio_b_gpo_o, gpio_b_gpd_o;

    // reference model state, updated on granted writes only
    gpio8_t  mdl_gpo_a = '0;
    gpio8_t  mdl_gpd_a = '0;
    gpio16_t mdl_gpo_b = '0;
    gpio16_t mdl_gpd_b = '0;
    data_t   mdl_scratch [`SCRATCH_DEPTH] = '{default: '0};
    master_t last_served = MST_B;           // so a takes the first tie

    logic [31:0] lfsr = 32'd66534;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    // pregenerated operands for the contention run
    addr_t stream_addr [2][STREAM_LEN];
    logic  stream_we   [2][STREAM_LEN];
    data_t stream_wd   [2][STREAM_LEN];

    tb_clkgen clkgen_inst
    (
        .clk_o    (clk),
        .resetn_o (resetn)
    );

    periph_top periph_top_inst (.*);

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic data_t rand_bits(input int n);
        data_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // regions 0..3 with hole 3 and gpio offsets on 0 4 8 c
    function automatic addr_t rand_addr();
        logic [3:0] region;
        logic [3:0] low;
        region = 4'(rand_bits(2));
        low    = 4'(rand_bits(4));      // scratch index or gpio offset
        return {20'h0, region, 2'b00, low, 2'b00};
    endfunction

    // expected read data from the address map and model state
    function automatic data_t expected_read(input addr_t addr);
        logic [3:0] ofs;
        data_t      r;
        ofs = addr[3:0];
        r   = '0;                       // unmapped regions read zero
        case (addr[11:8])
            `PBUS_REGION_GPIO_A:
            begin
                if (ofs == `GPIO_OFS_GPO)
                    r = {24'h0, mdl_gpo_a};
                else if (ofs == `GPIO_OFS_DIR)
                    r = {24'h0, mdl_gpd_a};
                else
                    r = {24'h0, gpio_a_gpi_i};  // gpi and holes
            end
            `PBUS_REGION_GPIO_B:
            begin
                if (ofs == `GPIO_OFS_GPO)
                    r = {16'h0, mdl_gpo_b};
                else if (ofs == `GPIO_OFS_DIR)
                    r = {16'h0, mdl_gpd_b};
                else
                    r = {16'h0, gpio_b_gpi_i};
            end
            `PBUS_REGION_SCRATCH:
                r = mdl_scratch[addr[5:2]];
            default:
                r = '0;
        endcase
        return r;
    endfunction

    // pin registers keep only their low bits
    function automatic void apply_write(input addr_t addr, input data_t wd);
        case (addr[11:8])
            `PBUS_REGION_GPIO_A:
            begin
                if (addr[3:0] == `GPIO_OFS_GPO)
                    mdl_gpo_a = wd[7:0];
                else if (addr[3:0] == `GPIO_OFS_DIR)
                    mdl_gpd_a = wd[7:0];
            end
            `PBUS_REGION_GPIO_B:
            begin
                if (addr[3:0] == `GPIO_OFS_GPO)
                    mdl_gpo_b = wd[15:0];
                else if (addr[3:0] == `GPIO_OFS_DIR)
                    mdl_gpd_b = wd[15:0];
            end
            `PBUS_REGION_SCRATCH:
                mdl_scratch[addr[5:2]] = wd;
            default: ;                  // holes drop the write
        endcase
    endfunction

    task automatic value_mismatch(input string name, input data_t got, input data_t exp);
        error_count++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h (t=%0t)", name, got, exp, $time);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR: %s (t=%0t)", what, $time);
    endtask

    task automatic check_word(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp)
            value_mismatch(name, got, exp);
    endtask

    task automatic check_pins8(input string name, input gpio8_t got, input gpio8_t exp);
        check_count++;
        if (got !== exp)
            value_mismatch(name, data_t'(got), data_t'(exp));
    endtask

    task automatic check_pins16(input string name, input gpio16_t got, input gpio16_t exp);
        check_count++;
        if (got !== exp)
            value_mismatch(name, data_t'(got), data_t'(exp));
    endtask

    task automatic check_grant(input string name, input master_t got, input master_t exp);
        check_count++;
        if (got !== exp)
            value_mismatch(name, data_t'(got), data_t'(exp));
    endtask

    task automatic score_access(input string name, input addr_t addr, input logic we,
                                input data_t wd, input data_t rd);
        if (we)
            apply_write(addr, wd);      // visible from the next cycle
        else
            check_word(name, rd, expected_read(addr));
    endtask

    // pins checked before this cycle's write lands
    task automatic score_cycle();
        master_t got;
        master_t exp;
        check_pins8("gpio_a_gpo_o", gpio_a_gpo_o, mdl_gpo_a);
        check_pins8("gpio_a_gpd_o", gpio_a_gpd_o, mdl_gpd_a);
        check_pins16("gpio_b_gpo_o", gpio_b_gpo_o, mdl_gpo_b);
        check_pins16("gpio_b_gpd_o", gpio_b_gpd_o, mdl_gpd_b);
        if (!a_req_i && !b_req_i)
        begin
            if (a_gnt_o || b_gnt_o)
                report_problem("grant raised while no master requests");
        end
        else if (a_gnt_o && b_gnt_o)
            report_problem("both masters granted in the same cycle");
        else if (!a_gnt_o && !b_gnt_o)
            report_problem("request pending but no master was granted");
        else
        begin
            got = a_gnt_o ? MST_A : MST_B;
            if (a_req_i && b_req_i)
                exp = (last_served == MST_A) ? MST_B : MST_A;   // not served last
            else
                exp = a_req_i ? MST_A : MST_B;                  // lone request
            check_grant("granted master", got, exp);
            last_served = exp;
            if (got == MST_A)
                score_access("a_rd_o", a_addr_i, a_we_i, a_wd_i, a_rd_o);
            else
                score_access("b_rd_o", b_addr_i, b_we_i, b_wd_i, b_rd_o);
        end
    endtask

    // request raised on an edge and held until the grant shows
    task automatic bus_access(input master_t m, input addr_t addr, input logic we,
                              input data_t wd);
        @(posedge clk);
        if (m == MST_A)
        begin
            a_req_i  <= 1'b1;
            a_addr_i <= addr;
            a_we_i   <= we;
            a_wd_i   <= wd;
        end
        else
        begin
            b_req_i  <= 1'b1;
            b_addr_i <= addr;
            b_we_i   <= we;
            b_wd_i   <= wd;
        end
        @(negedge clk);
        while (!((m == MST_A) ? a_gnt_o : b_gnt_o))
            @(negedge clk);
    endtask

    task automatic bus_release(input master_t m);
        @(posedge clk);
        if (m == MST_A)
            a_req_i <= 1'b0;
        else
            b_req_i <= 1'b0;
    endtask

    task automatic single_access(input master_t m, input addr_t addr, input logic we,
                                 input data_t wd);
        bus_access(m, addr, we, wd);
        bus_release(m);                 // drop right after the grant
    endtask

    // back-to-back accesses keep the request high
    task automatic run_stream(input master_t m);
        for (int i = 0; i < STREAM_LEN; i++)
            bus_access(m, stream_addr[m][i], stream_we[m][i], stream_wd[m][i]);
        bus_release(m);
    endtask

    always @(negedge clk)               // inputs settled since the rising edge
    begin
        if (resetn)
            score_cycle();
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("checks run: %0d, errors: %0d", check_count, error_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial
    begin
        master_t    m;
        addr_t      addr;
        data_t      wd;
        logic [3:0] region;
        logic [3:0] ofs;
        {a_req_i, a_we_i, a_addr_i, a_wd_i} = '0;
        {b_req_i, b_we_i, b_addr_i, b_wd_i} = '0;
        gpio_a_gpi_i = '0;
        gpio_b_gpi_i = '0;
        wait (resetn);

        // reset values read by a tie at the start
        fork
            single_access(MST_A, {20'h0, `PBUS_REGION_GPIO_A, 4'h0, `GPIO_OFS_GPO}, 1'b0, '0);
            single_access(MST_B, {20'h0, `PBUS_REGION_GPIO_B, 4'h0, `GPIO_OFS_DIR}, 1'b0, '0);
        join
        for (int i = 0; i < `SCRATCH_DEPTH; i++)
        begin
            m = (i % 2 == 0) ? MST_A : MST_B;
            single_access(m, {20'h0, `PBUS_REGION_SCRATCH, 2'b00, 4'(i), 2'b00}, 1'b0, '0);
        end

        // gpo and dir writes read back by either master
        repeat (24)
        begin
            region = rand_bits(1) ? `PBUS_REGION_GPIO_B : `PBUS_REGION_GPIO_A;
            ofs    = rand_bits(1) ? `GPIO_OFS_GPO : `GPIO_OFS_DIR;
            addr   = {20'h0, region, 4'h0, ofs};
            m      = rand_bits(1) ? MST_B : MST_A;
            wd     = rand_bits(32);     // upper bits fall away
            single_access(m, addr, 1'b1, wd);
            m = rand_bits(1) ? MST_B : MST_A;
            single_access(m, addr, 1'b0, '0);
        end

        // input pins at GPI and at holes
        repeat (14)
        begin
            @(posedge clk);
            gpio_a_gpi_i <= 8'(rand_bits(8));
            gpio_b_gpi_i <= 16'(rand_bits(16));
            region = rand_bits(1) ? `PBUS_REGION_GPIO_B : `PBUS_REGION_GPIO_A;
            ofs    = 4'(rand_bits(4));
            if (ofs == `GPIO_OFS_GPI || ofs == `GPIO_OFS_GPO || ofs == `GPIO_OFS_DIR)
                ofs = ofs | 4'h1;       // force a hole
            m = rand_bits(1) ? MST_B : MST_A;
            single_access(m, {20'h0, region, 4'h0, `GPIO_OFS_GPI}, 1'b0, '0);
            wd = rand_bits(32);
            single_access(m, {20'h0, region, 4'h0, ofs}, 1'b1, wd);    // dropped
            single_access(m, {20'h0, region, 4'h0, ofs}, 1'b0, '0);
        end

        // both masters busy at once
        for (int s = 0; s < 2; s++)
        begin
            for (int i = 0; i < STREAM_LEN; i++)
            begin
                stream_addr[s][i] = rand_addr();
                stream_we[s][i]   = 1'(rand_bits(1));
                stream_wd[s][i]   = rand_bits(32);
            end
        end
        fork
            run_stream(MST_A);
            run_stream(MST_B);
        join

        // scratch writes at random indices and writes into the holes
        repeat (20)
        begin
            m    = rand_bits(1) ? MST_B : MST_A;
            addr = {20'h0, `PBUS_REGION_SCRATCH, 2'b00, 4'(rand_bits(4)), 2'b00};
            wd   = rand_bits(32);
            single_access(m, addr, 1'b1, wd);
        end
        repeat (6)
        begin
            region = 4'(rand_bits(4));
            if (region < 4'h3)
                region = region + 4'h3; // regions 3..15 are unmapped
            addr = {20'h0, region, 8'(rand_bits(8))};
            wd   = rand_bits(32);
            single_access(MST_A, addr, 1'b1, wd);
            single_access(MST_B, addr, 1'b0, '0);  // zero
        end
        for (int i = 0; i < `SCRATCH_DEPTH; i++)
            single_access(MST_B, {20'h0, `PBUS_REGION_SCRATCH, 2'b00, 4'(i), 2'b00}, 1'b0, '0);

        repeat (2) @(posedge clk);      // last pin check
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule : tb_periph_top

/* verilog/gpio_pkg.sv */
// gpio pin vector types
package gpio_pkg;

    // narrow port, gpio_a
    typedef logic [7:0]  gpio8_t;

    // wide port, gpio_b
    typedef logic [15:0] gpio16_t;

endpackage : gpio_pkg

/* verilog/gpio_port.sv */
// gpio port registers
`timescale 1ns/1ps

`include "periph_consts.svh"

module gpio_port
#(
    parameter type pin_t = gpio_pkg::gpio8_t    // pin vector, sets the port width
)
(
    input  logic            clk,
    input  logic            resetn,
    // bus side
    input  pbus_pkg::addr_t addr_i,
    input  logic            we_i,       // strobe from the router
    input  pbus_pkg::data_t wd_i,
    output pbus_pkg::data_t rd_o,       // same cycle as the grant
    // pin side
    input  pin_t            gpi_i,      // input pins, unsynchronized
    output pin_t            gpo_o,      // output register
    output pin_t            gpd_o       // direction register
);
    import pbus_pkg::*;

    logic [3:0] ofs;        // register offset
    logic       gpo_we;
    logic       gpd_we;
    pin_t       gpo_q;
    pin_t       gpd_q;

    assign ofs    = addr_i[3:0];
    assign gpo_we = we_i && (ofs == `GPIO_OFS_GPO);
    assign gpd_we = we_i && (ofs == `GPIO_OFS_DIR);  // other offsets drop the write

    assign gpo_o = gpo_q;
    assign gpd_o = gpd_q;

    // readback, zero-extended onto the bus
    always_comb
    begin
        case (ofs)
            `GPIO_OFS_GPI: rd_o = data_t'(gpi_i);
            `GPIO_OFS_GPO: rd_o = data_t'(gpo_q);
            `GPIO_OFS_DIR: rd_o = data_t'(gpd_q);
            default:       rd_o = data_t'(gpi_i);    // holes show the pins
        endcase
    end

    // upper write bits are dropped
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            gpo_q <= '0;
            gpd_q <= '0;    // all pins start as inputs
        end
        else
        begin
            if (gpo_we)
                gpo_q <= pin_t'(wd_i);
            if (gpd_we)
                gpd_q <= pin_t'(wd_i);
        end
    end

    // a floating strobe would corrupt both registers
    we_known: assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(we_i))
        else $error("gpio_port: write strobe unknown");

endmodule : gpio_port

/* verilog/pbus_arbiter.sv */
// round-robin bus arbiter
`timescale 1ns/1ps

module pbus_arbiter
(
    input  logic            clk,
    input  logic            resetn,
    // master a
    input  logic            a_req_i,    // held until granted
    input  pbus_pkg::addr_t a_addr_i,
    input  logic            a_we_i,
    input  pbus_pkg::data_t a_wd_i,
    output logic            a_gnt_o,    // access happens this cycle
    // master b
    input  logic            b_req_i,
    input  pbus_pkg::addr_t b_addr_i,
    input  logic            b_we_i,
    input  pbus_pkg::data_t b_wd_i,
    output logic            b_gnt_o,
    // shared bus towards the router
    output pbus_pkg::addr_t bus_addr_o,
    output logic            bus_we_o,   // already qualified by grant
    output pbus_pkg::data_t bus_wd_o
);
    import pbus_pkg::*;

    master_t last_q;    // master served most recently
    logic    pick_b;    // b owns the bus this cycle

    // b alone, or b on a tie when a went last
    assign pick_b  = b_req_i && (!a_req_i || (last_q == MST_A));
    assign a_gnt_o = a_req_i && !pick_b;
    assign b_gnt_o = pick_b;

    // operand mux with a as the idle default
    assign bus_addr_o = pick_b ? b_addr_i : a_addr_i;
    assign bus_wd_o   = pick_b ? b_wd_i   : a_wd_i;
    assign bus_we_o   = pick_b ? (b_we_i && b_gnt_o) : (a_we_i && a_gnt_o);

    // round-robin pointer moves only on a grant
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            last_q <= MST_B;        // so a takes the first tie
        else if (a_gnt_o)
            last_q <= MST_A;
        else if (b_gnt_o)
            last_q <= MST_B;
    end

    // tie loser keeps its request and is served on the next cycle
    a_served_next: assert property (@(posedge clk) disable iff (!resetn)
        (a_req_i && !a_gnt_o) |=> a_gnt_o)
        else $error("pbus_arbiter: master a starved");

    b_served_next: assert property (@(posedge clk) disable iff (!resetn)
        (b_req_i && !b_gnt_o) |=> b_gnt_o)
        else $error("pbus_arbiter: master b starved");

endmodule : pbus_arbiter

/* verilog/pbus_pkg.sv */
// peripheral bus types
package pbus_pkg;

    // byte address from either master
    typedef logic [31:0] addr_t;

    // one bus word, read or write
    typedef logic [31:0] data_t;

    // which master owns the bus
    typedef enum logic [0:0]
    {
        MST_A = 1'b0,
        MST_B = 1'b1
    } master_t;

endpackage : pbus_pkg

/* verilog/pbus_router.sv */
// peripheral bus address router
`timescale 1ns/1ps

`include "periph_consts.svh"

module pbus_router
(
    // granted bus from the arbiter
    input  pbus_pkg::addr_t bus_addr_i,
    input  logic            bus_we_i,
    input  pbus_pkg::data_t bus_wd_i,
    output pbus_pkg::data_t bus_rd_o,   // zero for unmapped regions
    // peer side
    output logic            gpio_a_we_o,
    output logic            gpio_b_we_o,
    output logic            scratch_we_o,
    output pbus_pkg::addr_t per_addr_o, // shared by all peers
    output pbus_pkg::data_t per_wd_o,
    input  pbus_pkg::data_t gpio_a_rd_i,
    input  pbus_pkg::data_t gpio_b_rd_i,
    input  pbus_pkg::data_t scratch_rd_i
);
    logic [3:0] region;     // address bits 11:8
    logic [2:0] sel;        // one-hot region select
    logic [2:0] strobes;    // per-peer write strobes

    assign region = bus_addr_i[11:8];

    assign sel[0] = (region == `PBUS_REGION_GPIO_A);
    assign sel[1] = (region == `PBUS_REGION_GPIO_B);
    assign sel[2] = (region == `PBUS_REGION_SCRATCH);

    // an unmapped region raises no strobe
    assign strobes = {3{bus_we_i}} & sel;

    assign gpio_a_we_o  = strobes[0];
    assign gpio_b_we_o  = strobes[1];
    assign scratch_we_o = strobes[2];

    // peers decode their own low bits
    assign per_addr_o = bus_addr_i;
    assign per_wd_o   = bus_wd_i;

    // read data return
    always_comb
    begin
        if (sel[0])
            bus_rd_o = gpio_a_rd_i;
        else if (sel[1])
            bus_rd_o = gpio_b_rd_i;
        else if (sel[2])
            bus_rd_o = scratch_rd_i;
        else
            bus_rd_o = '0;          // hole in the map
    end

endmodule : pbus_router

/* verilog/periph_consts.svh */
// peripheral address map
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// region codes, matched against address bits 11:8
`define PBUS_REGION_GPIO_A      4'h0    // 8-pin port
`define PBUS_REGION_GPIO_B      4'h1    // 16-pin port
`define PBUS_REGION_SCRATCH     4'h2    // register file
// codes 3..15 are unmapped

// gpio register offsets, matched against address bits 3:0
`define GPIO_OFS_GPI            4'h0    // input pins, read only
`define GPIO_OFS_GPO            4'h4    // output register
`define GPIO_OFS_DIR            4'h8    // direction register

// scratch words, indexed by address bits 5:2
`define SCRATCH_DEPTH           16

`endif

/* verilog/periph_top.sv */
// peripheral subsystem top
`timescale 1ns/1ps

module periph_top
(
    input  logic                clk,
    input  logic                resetn,
    // master a
    input  logic                a_req_i,
    input  pbus_pkg::addr_t     a_addr_i,
    input  logic                a_we_i,
    input  pbus_pkg::data_t     a_wd_i,
    output logic                a_gnt_o,
    output pbus_pkg::data_t     a_rd_o,
    // master b
    input  logic                b_req_i,
    input  pbus_pkg::addr_t     b_addr_i,
    input  logic                b_we_i,
    input  pbus_pkg::data_t     b_wd_i,
    output logic                b_gnt_o,
    output pbus_pkg::data_t     b_rd_o,
    // 8-pin port
    input  gpio_pkg::gpio8_t    gpio_a_gpi_i,
    output gpio_pkg::gpio8_t    gpio_a_gpo_o,
    output gpio_pkg::gpio8_t    gpio_a_gpd_o,
    // 16-pin port
    input  gpio_pkg::gpio16_t   gpio_b_gpi_i,
    output gpio_pkg::gpio16_t   gpio_b_gpo_o,
    output gpio_pkg::gpio16_t   gpio_b_gpd_o
);
    import pbus_pkg::*;
    import gpio_pkg::*;

    // granted bus
    addr_t bus_addr;
    logic  bus_we;
    data_t bus_wd;
    data_t bus_rd;
    // peer side
    addr_t per_addr;
    data_t per_wd;
    logic  gpio_a_we;
    logic  gpio_b_we;
    logic  scratch_we;
    data_t gpio_a_rd;
    data_t gpio_b_rd;
    data_t scratch_rd;

    // both masters see the same read data
    assign a_rd_o = bus_rd;
    assign b_rd_o = bus_rd;

    pbus_arbiter arbiter_inst
    (
        .clk        (clk),
        .resetn     (resetn),
        .a_req_i    (a_req_i),
        .a_addr_i   (a_addr_i),
        .a_we_i     (a_we_i),
        .a_wd_i     (a_wd_i),
        .a_gnt_o    (a_gnt_o),
        .b_req_i    (b_req_i),
        .b_addr_i   (b_addr_i),
        .b_we_i     (b_we_i),
        .b_wd_i     (b_wd_i),
        .b_gnt_o    (b_gnt_o),
        .bus_addr_o (bus_addr),
        .bus_we_o   (bus_we),
        .bus_wd_o   (bus_wd)
    );

    pbus_router router_inst
    (
        .bus_addr_i   (bus_addr),
        .bus_we_i     (bus_we),
        .bus_wd_i     (bus_wd),
        .bus_rd_o     (bus_rd),
        .gpio_a_we_o  (gpio_a_we),
        .gpio_b_we_o  (gpio_b_we),
        .scratch_we_o (scratch_we),
        .per_addr_o   (per_addr),
        .per_wd_o     (per_wd),
        .gpio_a_rd_i  (gpio_a_rd),
        .gpio_b_rd_i  (gpio_b_rd),
        .scratch_rd_i (scratch_rd)
    );

    gpio_port #(.pin_t(gpio8_t)) gpio_a_inst     // region 0
    (
        .clk    (clk),
        .resetn (resetn),
        .addr_i (per_addr),
        .we_i   (gpio_a_we),
        .wd_i   (per_wd),
        .rd_o   (gpio_a_rd),
        .gpi_i  (gpio_a_gpi_i),
        .gpo_o  (gpio_a_gpo_o),
        .gpd_o  (gpio_a_gpd_o)
    );

    gpio_port #(.pin_t(gpio16_t)) gpio_b_inst    // region 1
    (
        .clk    (clk),
        .resetn (resetn),
        .addr_i (per_addr),
        .we_i   (gpio_b_we),
        .wd_i   (per_wd),
        .rd_o   (gpio_b_rd),
        .gpi_i  (gpio_b_gpi_i),
        .gpo_o  (gpio_b_gpo_o),
        .gpd_o  (gpio_b_gpd_o)
    );

    scratch_ram scratch_inst                        // region 2
    (
        .clk    (clk),
        .resetn (resetn),
        .addr_i (per_addr),
        .we_i   (scratch_we),
        .wd_i   (per_wd),
        .rd_o   (scratch_rd)
    );

endmodule : periph_top

/* verilog/scratch_ram.sv */
// scratch register file
`timescale 1ns/1ps

`include "periph_consts.svh"

module scratch_ram
(
    input  logic            clk,
    input  logic            resetn,
    input  pbus_pkg::addr_t addr_i,     // word index in bits 5:2
    input  logic            we_i,       // strobe from the router
    input  pbus_pkg::data_t wd_i,
    output pbus_pkg::data_t rd_o        // asynchronous read
);
    import pbus_pkg::*;

    localparam int IDX_W = $clog2(`SCRATCH_DEPTH);

    data_t            mem_q [`SCRATCH_DEPTH];
    logic [IDX_W-1:0] idx;     // word select

    assign idx  = addr_i[2 +: IDX_W];  // byte offset ignored
    assign rd_o = mem_q[idx];

    // whole array clears on reset
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < `SCRATCH_DEPTH; i++)
                mem_q[i] <= '0;
        end
        else if (we_i)
        begin
            mem_q[idx] <= wd_i;
        end
    end

endmodule : scratch_ram
